/* Makefile */
# Verilator build, run and lint for the capture target pad wrapper

VERILATOR  ?= verilator
TOP        ?= board_top_tb
RTL_TOP    ?= board_top
FILELIST   ?= board_top.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= Simulation passed
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "PASS: see $(LOG)"; \
	else \
		echo "FAIL: see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* board_top.f */
source/board_pkg.sv
source/pad_if.sv
source/pad_attr_ring.sv
source/debug_overlay_mux.sv
source/serial_cmd_port.sv
source/engine_ctrl_fsm.sv
source/cycle_timer.sv
source/gpio_core.sv
source/board_top.sv
sim/board_top_props.sv
sim/board_top_tb.sv

/* sim/board_top_props.sv */
////////////////////
// Bound assertions on reset state, debug pad drive and engine busy
////////////////////

`default_nettype none

module board_top_props (
  input logic                clk_main_i,
  input logic                rst_n_i,
  input logic                debug_strap_i,
  input logic                busy_i,
  input board_pkg::pad_vec_t pad_out_i,
  input board_pkg::pad_vec_t pad_oe_i
);
  import board_pkg::*;

  // Busy cycles seen so far in the current run
  logic [8:0] busy_run_q;

  always_ff @(posedge clk_main_i) begin
    if (!rst_n_i || !busy_i) begin
      busy_run_q <= '0;
    end else if (busy_run_q != '1) begin
      busy_run_q <= busy_run_q + 9'd1;
    end
  end

  a_reset_oe: assert property (@(posedge clk_main_i)
    !rst_n_i |=> (debug_strap_i || (pad_oe_i == '0)))
    else $error("pad output enables not cleared by reset");

  a_sdo_driven: assert property (@(posedge clk_main_i) disable iff (!rst_n_i)
    debug_strap_i |-> pad_oe_i[SdoPad])
    else $error("sdo pad not driven while the debug strap is set");

  a_trigger_idle: assert property (@(posedge clk_main_i) disable iff (!rst_n_i)
    !busy_i |-> !pad_out_i[TriggerPad])
    else $error("trigger pad high while the engine is idle");

  // Longest run is 255 cycles plus clearing
  a_busy_max: assert property (@(posedge clk_main_i) disable iff (!rst_n_i)
    busy_i |-> (busy_run_q < 9'd257))
    else $error("engine busy for more than 257 cycles");

endmodule

`default_nettype wire

/* sim/board_top_tb.sv */
////////////////////
// Testbench for the pad wrapper, serial frame driver, pad reference model,
// compare tasks and run timeout
////////////////////

`default_nettype none

module board_top_tb;
  import board_pkg::*;

  logic        clk_main = 1'b0;
  logic        rst_n;
  logic        debug_strap;
  pad_vec_t    pad_in;
  pad_vec_t    pad_out;
  pad_vec_t    pad_oe;

  // Model of the GPIO registers and the strap
  pad_vec_t    m_out;
  pad_vec_t    m_oe;
  pad_vec_t    m_inv;
  pad_vec_t    m_od;
  logic        m_strap;

  logic [31:0] rng_state;
  int          err_value;
  int          err_other;
  int          cycle_cnt = 0;
  // Running totals from the pad monitor, snapshots taken by the main process
  int          trig_total = 0;
  int          busy_total = 0;
  logic        busy_mon = 1'b0;
  int          trig_base;
  int          busy_base;

  board_top u_board_top (
    .clk_main_i    (clk_main),
    .rst_n_i       (rst_n),
    .debug_strap_i (debug_strap),
    .pad_in_i      (pad_in),
    .pad_out_o     (pad_out),
    .pad_oe_o      (pad_oe)
  );

  bind board_top board_top_props u_board_top_props (
    .clk_main_i    (clk_main_i),
    .rst_n_i       (rst_n_i),
    .debug_strap_i (debug_strap_i),
    .busy_i        (busy),
    .pad_out_i     (pad_out_o),
    .pad_oe_i      (pad_oe_o)
  );

  always #4 clk_main = ~clk_main;

  // Half a cycle after the registers move, sdo on pad 19 mirrors busy
  always @(negedge clk_main) begin
    busy_mon = pad_out[SdoPad];
    if (pad_out[SdoPad]) begin
      busy_total++;
    end
    if (pad_out[TriggerPad]) begin
      trig_total++;
    end
  end

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  //////////////////// Reference model
  function automatic void ref_pads(input logic strap, input logic busy,
                                   output pad_vec_t exp_out, output pad_vec_t exp_oe);
    pad_vec_t o;
    pad_vec_t e;
    pad_vec_t v;
    pad_vec_t d;
    o = m_out;
    e = m_oe;
    v = m_inv;
    d = m_od;
    o[TriggerPad] = m_out[TriggerPad] & busy;
    if (strap) begin
      for (int i = SckPad; i <= SdoPad; i++) begin
        o[i] = 1'b0;
        e[i] = 1'b0;
        v[i] = 1'b0;
        d[i] = 1'b0;
      end
      o[SdoPad] = busy;
      e[SdoPad] = 1'b1;
    end
    exp_out = o ^ v;
    // Open drain drives only a low level
    exp_oe = e & ~(d & exp_out);
  endfunction

  //////////////////// Compare tasks
  task automatic check_pads(input string name, input pad_vec_t exp, input pad_vec_t act);
    if (act !== exp) begin
      err_value++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_busy_len(input string name, input engine_len_t exp,
                                input engine_len_t act);
    if (act !== exp) begin
      err_value++;
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_now(input string name, input logic busy);
    pad_vec_t exp_out;
    pad_vec_t exp_oe;
    @(negedge clk_main);
    ref_pads(m_strap, busy, exp_out, exp_oe);
    check_pads({name, " out"}, exp_out, pad_out);
    check_pads({name, " oe"}, exp_oe, pad_oe);
  endtask

  //////////////////// Serial frames
  // Sends word[nbits-1:0] MSB first
  task automatic send_frame(input logic [31:0] word, input int nbits);
    @(posedge clk_main);
    pad_in[CsbPad] <= 1'b0;
    for (int i = nbits - 1; i >= 0; i--) begin
      repeat (4) @(posedge clk_main);
      pad_in[SckPad] <= 1'b0;
      pad_in[SdiPad] <= word[i];
      repeat (4) @(posedge clk_main);
      pad_in[SckPad] <= 1'b1;
    end
    repeat (4) @(posedge clk_main);
    pad_in[SckPad] <= 1'b0;
    repeat (4) @(posedge clk_main);
    pad_in[CsbPad] <= 1'b1;
    repeat (8) @(posedge clk_main);
  endtask

  task automatic write_reg(input cmd_op_t op, input pad_vec_t data, input string name);
    send_frame({8'h00, op, data}, FrameBits);
    case (op)
      OpWrOut: m_out = data;
      OpWrOe:  m_oe  = data;
      OpWrInv: m_inv = data;
      OpWrOd:  m_od  = data;
      default: begin
      end
    endcase
    check_now(name, 1'b0);
  endtask

  task automatic start_engine(input engine_len_t n);
    @(posedge clk_main);
    trig_base = trig_total;
    busy_base = busy_total;
    send_frame({8'h00, OpStart, 12'h000, n}, FrameBits);
  endtask

  // Waits for busy to rise, or for a run to have ended
  task automatic wait_engine(input logic to_end, input string name);
    int waited;
    waited = 0;
    while (!(to_end ? ((busy_total != busy_base) && !busy_mon) : busy_mon) &&
           (waited < 1000)) begin
      @(posedge clk_main);
      waited++;
    end
    if (waited >= 1000) begin
      err_other++;
      $display("%s: engine busy did not %s within 1000 cycles", name,
               to_end ? "end" : "start");
    end
  endtask

  task automatic run_capture(input engine_len_t n, input string name);
    engine_len_t exp_len;
    exp_len = m_out[TriggerPad] ? n + ClearCycles : 8'd0;
    start_engine(n);
    wait_engine(1'b1, name);
    check_busy_len(name, exp_len, engine_len_t'(trig_total - trig_base));
  endtask

  initial begin
    while (cycle_cnt < 20000) begin
      @(posedge clk_main);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", cycle_cnt);
    $display("Simulation failed");
    $finish;
  end

  //////////////////// Test sequence
  initial begin
    engine_len_t n;
    pad_vec_t    data;
    rst_n          = 1'b0;
    debug_strap    = 1'b0;
    pad_in         = '0;
    pad_in[CsbPad] = 1'b1;
    m_out          = '0;
    m_oe           = '0;
    m_inv          = '0;
    m_od           = '0;
    m_strap        = 1'b0;
    rng_state      = 32'd63964;
    err_value      = 0;
    err_other      = 0;
    trig_base      = 0;
    busy_base      = 0;
    repeat (4) @(posedge clk_main);
    rst_n <= 1'b1;
    check_now("reset", 1'b0);

    @(posedge clk_main);
    debug_strap <= 1'b1;
    m_strap = 1'b1;
    check_now("strap on", 1'b0);
    for (int i = 0; i < 3; i++) begin
      write_reg(OpWrOut, pad_vec_t'(xorshift32()), "gpio out");
      write_reg(OpWrOe, pad_vec_t'(xorshift32()), "gpio oe");
    end

    // Trigger polarity stays fixed
    for (int i = 0; i < 3; i++) begin
      data = pad_vec_t'(xorshift32());
      data[TriggerPad] = 1'b0;
      write_reg(OpWrInv, data, "attr inv");
      write_reg(OpWrOd, pad_vec_t'(xorshift32()), "attr od");
      write_reg(OpWrOut, pad_vec_t'(xorshift32()), "attr out");
    end

    //////////////////// Capture trigger
    data = pad_vec_t'(xorshift32());
    data[TriggerPad] = 1'b1;
    write_reg(OpWrOut, data, "trigger set");
    for (int i = 0; i < 3; i++) begin
      run_capture(engine_len_t'(xorshift32() & 32'h3f), "capture random");
    end
    run_capture(8'd0, "capture zero");

    // Long run, a second start lands while busy
    n = 8'd250;
    start_engine(n);
    wait_engine(1'b0, "first start");
    check_now("capture busy", 1'b1);
    send_frame({8'h00, OpStart, 12'h000, 8'd3}, FrameBits);
    wait_engine(1'b1, "double start");
    check_busy_len("double start", n + ClearCycles, engine_len_t'(trig_total - trig_base));
    repeat (20) @(posedge clk_main);
    check_busy_len("after double start", n + ClearCycles,
                   engine_len_t'(trig_total - trig_base));

    data[TriggerPad] = 1'b0;
    write_reg(OpWrOut, data, "trigger clear");
    run_capture(engine_len_t'(xorshift32() & 32'h3f), "capture masked");

    //////////////////// Bad frame lengths
    // Long frame ends on a valid write; its last bit stays zero so the
    // short frame after it also lines up to a valid write opcode
    data = pad_vec_t'(xorshift32());
    data[0] = 1'b0;
    send_frame({8'h00, OpWrOut, data}, FrameBits + 1);
    check_now("long frame", 1'b0);
    send_frame({8'h00, OpWrOut, ~data}, FrameBits - 1);
    check_now("short frame", 1'b0);

    @(posedge clk_main);
    debug_strap <= 1'b0;
    m_strap = 1'b0;
    check_now("strap off", 1'b0);

    $display("Error counts: %0d value mismatches, %0d other failures", err_value, err_other);
    if ((err_value == 0) && (err_other == 0)) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/board_pkg.sv */
////////////////////
// Shared sizes, pad indices, engine timing, opcodes and vector types
// for the capture target pad wrapper
////////////////////

`default_nettype none

package board_pkg;

  //////////////////// Sizes
  localparam int NumPads   = 20;
  localparam int FrameBits = 24;

  // Pad indices
  localparam int TriggerPad = 15;
  localparam int SckPad     = 16;
  localparam int CsbPad     = 17;
  localparam int SdiPad     = 18;
  localparam int SdoPad     = 19;

  //////////////////// Types
  typedef logic [NumPads-1:0]   pad_vec_t;
  typedef logic [3:0]           cmd_op_t;
  typedef logic [FrameBits-1:0] frame_t;
  typedef logic [7:0]           engine_len_t;

  // Bit counter saturates one past a full frame
  localparam int FrameCntW = $clog2(FrameBits + 2);
  typedef logic [FrameCntW-1:0] frame_cnt_t;
  localparam frame_cnt_t FrameCntFull = frame_cnt_t'(FrameBits);
  localparam frame_cnt_t FrameCntMax  = frame_cnt_t'(FrameBits + 1);

  // Pads taken over by the serial port
  localparam pad_vec_t DbgPadMask = pad_vec_t'((1 << SckPad) | (1 << CsbPad) |
                                               (1 << SdiPad) | (1 << SdoPad));

  // Engine timing
  localparam engine_len_t StartDelay  = 8'd4;
  localparam engine_len_t ClearCycles = 8'd2;

  // Opcodes, anything else is ignored
  localparam cmd_op_t OpWrOut = 4'd1;
  localparam cmd_op_t OpWrOe  = 4'd2;
  localparam cmd_op_t OpWrInv = 4'd3;
  localparam cmd_op_t OpWrOd  = 4'd4;
  localparam cmd_op_t OpStart = 4'd5;

  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_ARM,
    ENG_RUN,
    ENG_CLEAR
  } eng_state_t;

endpackage

`default_nettype wire

/* source/board_top.sv */
////////////////////
// Top level of the capture target pad wrapper
////////////////////

`default_nettype none

module board_top (
  input  logic                clk_main_i,
  input  logic                rst_n_i,
  input  logic                debug_strap_i,
  input  board_pkg::pad_vec_t pad_in_i,
  output board_pkg::pad_vec_t pad_out_o,
  output board_pkg::pad_vec_t pad_oe_o
);
  import board_pkg::*;

  logic        wr;
  cmd_op_t     wr_op;
  pad_vec_t    wr_data;
  logic        start;
  engine_len_t start_len;
  logic        busy;
  logic        tmr_load;
  engine_len_t tmr_value;
  logic        tmr_expired;

  pad_if u_core_pads ();
  pad_if u_ring_pads ();
  dbg_if u_dbg ();

  //////////////////// Pads
  pad_attr_ring u_pad_attr_ring (
    .core      (u_ring_pads),
    .pad_in_i  (pad_in_i),
    .pad_out_o (pad_out_o),
    .pad_oe_o  (pad_oe_o)
  );

  debug_overlay_mux u_debug_overlay_mux (
    .debug_strap_i (debug_strap_i),
    .core          (u_core_pads),
    .ring          (u_ring_pads),
    .dbg           (u_dbg)
  );

  //////////////////// Core
  serial_cmd_port u_serial_cmd_port (
    .clk_main_i  (clk_main_i),
    .rst_n_i     (rst_n_i),
    .dbg         (u_dbg),
    .wr_o        (wr),
    .wr_op_o     (wr_op),
    .wr_data_o   (wr_data),
    .start_o     (start),
    .start_len_o (start_len),
    .busy_i      (busy)
  );

  gpio_core u_gpio_core (
    .clk_main_i (clk_main_i),
    .rst_n_i    (rst_n_i),
    .wr_i       (wr),
    .wr_op_i    (wr_op),
    .wr_data_i  (wr_data),
    .busy_i     (busy),
    .pads       (u_core_pads)
  );

  engine_ctrl_fsm u_engine_ctrl_fsm (
    .clk_main_i    (clk_main_i),
    .rst_n_i       (rst_n_i),
    .start_i       (start),
    .len_i         (start_len),
    .tmr_load_o    (tmr_load),
    .tmr_value_o   (tmr_value),
    .tmr_expired_i (tmr_expired),
    .busy_o        (busy)
  );

  cycle_timer u_cycle_timer (
    .clk_main_i (clk_main_i),
    .rst_n_i    (rst_n_i),
    .load_i     (tmr_load),
    .value_i    (tmr_value),
    .expired_o  (tmr_expired)
  );

endmodule

`default_nettype wire

/* source/cycle_timer.sv */
////////////////////
// Loadable down-counter with expiry flag
////////////////////

`default_nettype none

module cycle_timer (
  input  logic                   clk_main_i,
  input  logic                   rst_n_i,
  input  logic                   load_i,
  input  board_pkg::engine_len_t value_i,
  output logic                   expired_o
);
  import board_pkg::*;

  engine_len_t cnt_q;
  // Set for one cycle after a load of zero
  logic        zero_q;

  always_ff @(posedge clk_main_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      zero_q <= 1'b0;
    end else if (load_i) begin
      cnt_q  <= value_i;
      zero_q <= (value_i == '0);
    end else begin
      zero_q <= 1'b0;
      if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  assign expired_o = (cnt_q == engine_len_t'(1)) || zero_q;

endmodule

`default_nettype wire

/* source/debug_overlay_mux.sv */
////////////////////
// Strap-selected overlay of the serial debug port on pads 16 to 19
////////////////////

`default_nettype none

module debug_overlay_mux (
  input  logic     debug_strap_i,
  pad_if.mux_side  core,
  pad_if.core_side ring,
  dbg_if.host      dbg
);
  import board_pkg::*;

  //////////////////// Pad side
  always_comb begin
    ring.out = core.out;
    ring.oe  = core.oe;
    ring.inv = core.inv;
    ring.od  = core.od;

    if (debug_strap_i) begin
      // Debug pads lose core control and plain attributes
      ring.out = core.out & ~DbgPadMask;
      ring.oe  = core.oe & ~DbgPadMask;
      ring.inv = core.inv & ~DbgPadMask;
      ring.od  = core.od & ~DbgPadMask;

      // Only sdo is driven, the others are inputs
      ring.out[SdoPad] = dbg.sdo;
      ring.oe[SdoPad]  = 1'b1;
    end
  end

  //////////////////// Serial port side
  always_comb begin
    // Idle port while the strap is low
    dbg.sck = 1'b0;
    dbg.csb = 1'b1;
    dbg.sdi = 1'b0;

    if (debug_strap_i) begin
      dbg.sck = ring.in[SckPad];
      dbg.csb = ring.in[CsbPad];
      dbg.sdi = ring.in[SdiPad];
    end
  end

endmodule

`default_nettype wire

/* source/engine_ctrl_fsm.sv */
////////////////////
// Operation engine FSM, arm, run and clear phases with busy flag
////////////////////

`default_nettype none

module engine_ctrl_fsm (
  input  logic                   clk_main_i,
  input  logic                   rst_n_i,
  input  logic                   start_i,
  input  board_pkg::engine_len_t len_i,
  output logic                   tmr_load_o,
  output board_pkg::engine_len_t tmr_value_o,
  input  logic                   tmr_expired_i,
  output logic                   busy_o
);
  import board_pkg::*;

  eng_state_t  state_q;
  eng_state_t  state_d;
  engine_len_t len_q;

  always_comb begin
    state_d     = state_q;
    tmr_load_o  = 1'b0;
    tmr_value_o = StartDelay;

    unique case (state_q)
      ENG_IDLE: begin
        if (start_i) begin
          state_d    = ENG_ARM;
          tmr_load_o = 1'b1;
        end
      end
      ENG_ARM: begin
        if (tmr_expired_i) begin
          tmr_load_o = 1'b1;
          if (len_q == '0) begin
            // Zero length run goes straight to clearing
            state_d     = ENG_CLEAR;
            tmr_value_o = ClearCycles;
          end else begin
            state_d     = ENG_RUN;
            tmr_value_o = len_q;
          end
        end
      end
      ENG_RUN: begin
        if (tmr_expired_i) begin
          state_d     = ENG_CLEAR;
          tmr_load_o  = 1'b1;
          tmr_value_o = ClearCycles;
        end
      end
      ENG_CLEAR: begin
        if (tmr_expired_i) begin
          state_d = ENG_IDLE;
        end
      end
      default: state_d = ENG_IDLE;
    endcase
  end

  always_ff @(posedge clk_main_i) begin
    if (!rst_n_i) begin
      state_q <= ENG_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Run length latched at start, later starts are ignored
  always_ff @(posedge clk_main_i) begin
    if ((state_q == ENG_IDLE) && start_i) begin
      len_q <= len_i;
    end
  end

  assign busy_o = (state_q == ENG_RUN) || (state_q == ENG_CLEAR);

endmodule

`default_nettype wire

/* source/gpio_core.sv */
////////////////////
// GPIO out, oe, invert and open-drain registers, capture-trigger gating
////////////////////

`default_nettype none

module gpio_core (
  input  logic                clk_main_i,
  input  logic                rst_n_i,
  input  logic                wr_i,
  input  board_pkg::cmd_op_t  wr_op_i,
  input  board_pkg::pad_vec_t wr_data_i,
  input  logic                busy_i,
  pad_if.core                 pads
);
  import board_pkg::*;

  pad_vec_t out_q;
  pad_vec_t oe_q;
  pad_vec_t inv_q;
  pad_vec_t od_q;

  always_ff @(posedge clk_main_i) begin
    if (!rst_n_i) begin
      out_q <= '0;
      oe_q  <= '0;
      inv_q <= '0;
      od_q  <= '0;
    end else if (wr_i) begin
      case (wr_op_i)
        OpWrOut: out_q <= wr_data_i;
        OpWrOe:  oe_q  <= wr_data_i;
        OpWrInv: inv_q <= wr_data_i;
        OpWrOd:  od_q  <= wr_data_i;
        default: begin
        end
      endcase
    end
  end

  //////////////////// Capture trigger
  // Software trigger only reaches the pad while the engine is busy
  always_comb begin
    pads.out             = out_q;
    pads.out[TriggerPad] = out_q[TriggerPad] & busy_i;
  end

  assign pads.oe  = oe_q;
  assign pads.inv = inv_q;
  assign pads.od  = od_q;

endmodule

`default_nettype wire

/* source/pad_attr_ring.sv */
////////////////////
// Pad ring, applies per-pad invert and open-drain attributes
////////////////////

`default_nettype none

module pad_attr_ring (
  pad_if.ring                  core,
  input  board_pkg::pad_vec_t  pad_in_i,
  output board_pkg::pad_vec_t  pad_out_o,
  output board_pkg::pad_vec_t  pad_oe_o
);
  import board_pkg::*;

  // Output level after inversion
  pad_vec_t out_val;

  for (genvar i = 0; i < NumPads; i++) begin : gen_pad
    assign out_val[i] = core.out[i] ^ core.inv[i];

    // Open drain only pulls low, releases the pad for a high level
    assign pad_oe_o[i] = core.od[i] ? (core.oe[i] & ~out_val[i]) : core.oe[i];

    assign pad_out_o[i] = out_val[i];

    // Input path sees the same polarity as the output path
    assign core.in[i] = pad_in_i[i] ^ core.inv[i];
  end

endmodule

`default_nettype wire

/* source/pad_if.sv */
////////////////////
// Pad bundle interface and serial debug pin interface
////////////////////

`default_nettype none

interface pad_if;
  import board_pkg::*;

  pad_vec_t out;
  pad_vec_t oe;
  pad_vec_t inv;
  pad_vec_t od;
  pad_vec_t in;

  // GPIO block, drives attributes only
  modport core (output out, oe, inv, od);
  // Overlay mux facing the GPIO block
  modport mux_side (input out, oe, inv, od);
  // Overlay mux facing the pad ring
  modport core_side (output out, oe, inv, od, input in);
  modport ring (input out, oe, inv, od, output in);
endinterface

interface dbg_if;
  logic sck;
  logic csb;
  logic sdi;
  logic sdo;

  modport host (output sck, csb, sdi, input sdo);
  modport device (input sck, csb, sdi, output sdo);
endinterface

`default_nettype wire

/* source/serial_cmd_port.sv */
////////////////////
// Synchronous serial command port, 24-bit frames MSB first,
// issues register writes and engine starts
////////////////////

`default_nettype none

module serial_cmd_port (
  input  logic                   clk_main_i,
  input  logic                   rst_n_i,
  dbg_if.device                  dbg,
  output logic                   wr_o,
  output board_pkg::cmd_op_t     wr_op_o,
  output board_pkg::pad_vec_t    wr_data_o,
  output logic                   start_o,
  output board_pkg::engine_len_t start_len_o,
  input  logic                   busy_i
);
  import board_pkg::*;

  // Synchronized pins packed as {sck, csb, sdi}
  logic [2:0] pin_q1;
  logic [2:0] pin_q2;
  // Previous {sck, csb} for edge detection
  logic [1:0] edge_q;

  logic       sck_rise;
  logic       csb_rise;
  logic       csb_low;
  logic       sdi_s;

  frame_t     shift_q;
  frame_t     frame_q;
  frame_cnt_t cnt_q;
  cmd_op_t    frame_op;
  logic       frame_ok;

  //////////////////// Synchronizer
  always_ff @(posedge clk_main_i) begin
    if (!rst_n_i) begin
      pin_q1 <= 3'b010;
      pin_q2 <= 3'b010;
      edge_q <= 2'b01;
    end else begin
      pin_q1 <= {dbg.sck, dbg.csb, dbg.sdi};
      pin_q2 <= pin_q1;
      edge_q <= pin_q2[2:1];
    end
  end

  assign sck_rise = pin_q2[2] & ~edge_q[1];
  assign csb_rise = pin_q2[1] & ~edge_q[0];
  assign csb_low  = ~pin_q2[1];
  assign sdi_s    = pin_q2[0];

  //////////////////// Frame shifter
  always_ff @(posedge clk_main_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (!csb_low) begin
      cnt_q <= '0;
    end else if (sck_rise && (cnt_q != FrameCntMax)) begin
      // Sticks at max so overlong frames are rejected
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_main_i) begin
    if (csb_low && sck_rise) begin
      shift_q <= {shift_q[FrameBits-2:0], sdi_s};
    end
  end

  assign frame_op = shift_q[FrameBits-1 -: $bits(cmd_op_t)];
  assign frame_ok = csb_rise && (cnt_q == FrameCntFull);

  //////////////////// Commit
  always_ff @(posedge clk_main_i) begin
    if (!rst_n_i) begin
      wr_o    <= 1'b0;
      start_o <= 1'b0;
    end else begin
      wr_o    <= frame_ok && (frame_op inside {OpWrOut, OpWrOe, OpWrInv, OpWrOd});
      start_o <= frame_ok && (frame_op == OpStart);
    end
  end

  always_ff @(posedge clk_main_i) begin
    if (frame_ok) begin
      frame_q <= shift_q;
    end
  end

  assign wr_op_o     = frame_q[FrameBits-1 -: $bits(cmd_op_t)];
  assign wr_data_o   = frame_q[NumPads-1:0];
  assign start_len_o = frame_q[$bits(engine_len_t)-1:0];

  // Host polls engine status on sdo
  assign dbg.sdo = busy_i;

endmodule

`default_nettype wire
